//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_intra_block_coder
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+tests
hdl/intra_pkg.sv
hdl/coef_if.sv
hdl/residual_collector.sv
hdl/block_transform.sv
hdl/coef_quantizer.sv
hdl/intra_block_coder.sv
tests/tb_intra_block_coder.sv

//--- hdl/block_transform.sv
`default_nettype none

module block_transform
    import intra_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      load,
    input  wire residual_t blk_res [BLOCK_SAMPLES],
    input  wire qp_t       blk_qp,
    coef_if.src            out
);

    localparam coef_idx_t LAST_COEF = coef_idx_t'(BLOCK_SAMPLES - 1);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } xform_state_t;

    xform_state_t state;
    coef_idx_t    cnt;
    residual_t    blk_q [BLOCK_SAMPLES];
    qp_t          qp_q;
    residual_t    src [BLOCK_SAMPLES];
    coef_idx_t    k_sel;
    coef_t        coef_next;
    logic         emit;

    // sign of basis entry h(row, col), 1 means subtract
    function automatic logic basis_neg(input logic [1:0] row, input logic [1:0] col);
        logic neg;
        case (row)
            2'd0:    neg = 1'b0;
            2'd1:    neg = col[1];
            2'd2:    neg = col[1] ^ col[0];
            default: neg = col[0];
        endcase
        return neg;
    endfunction

    // ============================================================
    // block copy
    // ============================================================

    always_ff @(posedge clk) begin
        if (load) begin
            blk_q <= blk_res;
            qp_q  <= blk_qp;
        end
    end

    // coefficient 0 is built straight from the collector buffer,
    // the rest from the local copy
    always_comb begin
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            src[i] = load ? blk_res[i] : blk_q[i];
        end
    end

    assign k_sel = load ? '0 : cnt;
    assign emit  = load || (state == S_RUN);

    // ============================================================
    // +-1 basis sum, coefficient k = 4u + v
    // ============================================================

    always_comb begin : basis_sum
        coef_t     term;
        coef_idx_t pos;
        coef_next = '0;
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            pos  = coef_idx_t'(i);
            term = coef_t'(src[i]);
            if (basis_neg(k_sel[3:2], pos[3:2]) ^ basis_neg(k_sel[1:0], pos[1:0])) begin
                coef_next = coef_next - term;
            end else begin
                coef_next = coef_next + term;
            end
        end
    end

    // ============================================================
    // output sequencing
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cnt       <= '0;
            out.valid <= 1'b0;
        end else begin
            out.valid <= emit;
            if (load) begin
                state <= S_RUN;
                cnt   <= coef_idx_t'(1);
            end else if (state == S_RUN) begin
                cnt <= cnt + 1'b1;
                // last coefficient goes out this edge
                if (cnt == LAST_COEF) begin
                    state <= S_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out.coef <= coef_next;
            out.idx  <= k_sel;
            out.qp   <= load ? blk_qp : qp_q;
        end
    end

endmodule

`default_nettype wire

//--- hdl/coef_if.sv
`default_nettype none

// one coefficient per strobe, with its position and block QP
interface coef_if
    import intra_pkg::*;
();

    logic      valid;
    coef_t     coef;
    coef_idx_t idx;
    qp_t       qp;

    // transform side
    modport src (
        output valid,
        output coef,
        output idx,
        output qp
    );

    // quantizer side
    modport dst (
        input valid,
        input coef,
        input idx,
        input qp
    );

endinterface

`default_nettype wire

//--- hdl/coef_quantizer.sv
`default_nettype none

module coef_quantizer
    import intra_pkg::*;
#(
    parameter int LEVEL_W = 16
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    coef_if.dst                       in,
    output logic                      out_valid,
    output logic signed [LEVEL_W-1:0] out_level
);

    localparam int MF_W   = 14;
    localparam int OFS_W  = 18;
    // |coef| * MF + f stays below 2^27
    localparam int PROD_W = COEF_W + MF_W + 1;

    localparam logic [1:0] CLS_A = 2'd0;
    localparam logic [1:0] CLS_B = 2'd1;
    localparam logic [1:0] CLS_C = 2'd2;

    typedef logic [MF_W-1:0] mf_t;

    logic [2:0]         qp_rem;
    logic [2:0]         qp_div;
    logic [1:0]         pos_cls;
    mf_t                mf;
    logic [4:0]         qbits;
    logic [OFS_W-1:0]   f_ofs;
    logic [COEF_W-1:0]  coef_mag;
    logic [PROD_W-1:0]  scaled;
    logic [PROD_W-1:0]  mag;
    logic signed [LEVEL_W-1:0] level_next;

    assign qp_div = 3'(in.qp / 5'd6);
    assign qp_rem = 3'(in.qp % 5'd6);

    // ============================================================
    // table lookup
    // ============================================================

    always_comb begin
        case (in.idx)
            4'd0, 4'd2, 4'd8, 4'd10:  pos_cls = CLS_A;
            4'd5, 4'd7, 4'd13, 4'd15: pos_cls = CLS_B;
            default:                  pos_cls = CLS_C;
        endcase
    end

    always_comb begin
        mf = '0;
        case (pos_cls)
            CLS_A: begin
                case (qp_rem)
                    3'd0:    mf = 14'd13107;
                    3'd1:    mf = 14'd11916;
                    3'd2:    mf = 14'd10082;
                    3'd3:    mf = 14'd9362;
                    3'd4:    mf = 14'd8192;
                    default: mf = 14'd7282;
                endcase
            end
            CLS_B: begin
                case (qp_rem)
                    3'd0:    mf = 14'd5243;
                    3'd1:    mf = 14'd4660;
                    3'd2:    mf = 14'd4194;
                    3'd3:    mf = 14'd3647;
                    3'd4:    mf = 14'd3355;
                    default: mf = 14'd2893;
                endcase
            end
            default: begin
                case (qp_rem)
                    3'd0:    mf = 14'd8066;
                    3'd1:    mf = 14'd7490;
                    3'd2:    mf = 14'd6554;
                    3'd3:    mf = 14'd5825;
                    3'd4:    mf = 14'd5243;
                    default: mf = 14'd4559;
                endcase
            end
        endcase
    end

    // rounding offset is about a third of the quantizer step
    always_comb begin
        case (qp_div)
            3'd0:    f_ofs = 18'd10922;
            3'd1:    f_ofs = 18'd21845;
            3'd2:    f_ofs = 18'd43690;
            3'd3:    f_ofs = 18'd87381;
            default: f_ofs = 18'd174762;
        endcase
    end

    assign qbits = (qp_div > 3'd4) ? 5'd19 : 5'd15 + 5'(qp_div);

    // ============================================================
    // scale, round, restore sign
    // ============================================================

    assign coef_mag   = in.coef[COEF_W-1] ? -in.coef : in.coef;
    assign scaled     = PROD_W'(coef_mag) * PROD_W'(mf) + PROD_W'(f_ofs);
    assign mag        = scaled >> qbits;
    assign level_next = in.coef[COEF_W-1] ? -LEVEL_W'(mag) : LEVEL_W'(mag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_level <= '0;
        end else begin
            out_valid <= in.valid;
            out_level <= in.valid ? level_next : '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/intra_block_coder.sv
`default_nettype none

module intra_block_coder
    import intra_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   in_valid,
    input  wire pixel_t pixel,
    input  wire pixel_t pred,
    input  wire qp_t    qp,
    output logic        out_valid,
    output level_t      out_level
);

    localparam int LEVEL_W = $bits(level_t);

    // ============================================================
    // stage links
    // ============================================================

    logic      load;
    residual_t blk_res [BLOCK_SAMPLES];
    qp_t       blk_qp;

    coef_if coef_bus ();

    // ============================================================
    // collect -> transform -> quantize
    // ============================================================

    residual_collector u_collect (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .pixel    (pixel),
        .pred     (pred),
        .qp       (qp),
        .load     (load),
        .blk_res  (blk_res),
        .blk_qp   (blk_qp)
    );

    // second block can be collected while this one streams out
    block_transform u_xform (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .blk_res (blk_res),
        .blk_qp  (blk_qp),
        .out     (coef_bus)
    );

    coef_quantizer #(
        .LEVEL_W (LEVEL_W)
    ) u_quant (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (coef_bus),
        .out_valid (out_valid),
        .out_level (out_level)
    );

endmodule

`default_nettype wire

//--- hdl/intra_pkg.sv
`default_nettype none

package intra_pkg;

    // ============================================================
    // sample widths
    // ============================================================

    // raw pixel and prediction samples
    localparam int PIXEL_W = 8;

    // pixel minus prediction spans -255..255
    localparam int RES_W = PIXEL_W + 1;

    // ============================================================
    // block geometry
    // ============================================================

    localparam int BLOCK_SAMPLES = 16;

    // position inside a block, 4*row + column
    localparam int IDX_W = $clog2(BLOCK_SAMPLES);

    // ============================================================
    // coefficient, level and QP widths
    // ============================================================

    // sum of 16 residuals with +-1 weights, magnitude up to 16*255
    localparam int COEF_W = RES_W + $clog2(BLOCK_SAMPLES);

    // quantized level as seen on the output port
    localparam int LEVEL_BITS = 16;

    localparam int QP_W = 5;

    // MF and offset tables are only consistent up to here
    localparam int QP_MAX = 29;

    // ============================================================
    // types
    // ============================================================

    typedef logic        [PIXEL_W-1:0]    pixel_t;
    typedef logic signed [RES_W-1:0]      residual_t;
    typedef logic signed [COEF_W-1:0]     coef_t;
    typedef logic signed [LEVEL_BITS-1:0] level_t;
    typedef logic        [QP_W-1:0]       qp_t;
    typedef logic        [IDX_W-1:0]      coef_idx_t;

endpackage

`default_nettype wire

//--- hdl/residual_collector.sv
`default_nettype none

module residual_collector
    import intra_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      in_valid,
    input  wire pixel_t    pixel,
    input  wire pixel_t    pred,
    input  wire qp_t       qp,
    output logic           load,
    output residual_t      blk_res [BLOCK_SAMPLES],
    output qp_t            blk_qp
);

    localparam coef_idx_t LAST_SLOT = coef_idx_t'(BLOCK_SAMPLES - 1);

    // ============================================================
    // residual on arrival
    // ============================================================

    coef_idx_t slot;
    residual_t res_new;

    // both operands zero-extended so the difference keeps its sign
    assign res_new = $signed({1'b0, pixel}) - $signed({1'b0, pred});

    // ============================================================
    // sample counter and block-complete strobe
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
            load <= 1'b0;
        end else begin
            load <= in_valid && (slot == LAST_SLOT);
            if (in_valid) begin
                if (slot == LAST_SLOT) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // ============================================================
    // block buffer
    // ============================================================

    // slot 15 lands on the same edge that raises load, so the
    // transform sees a complete block while load is high
    always_ff @(posedge clk) begin
        if (in_valid) begin
            blk_res[slot] <= res_new;
            // qp only counts on the first sample of a block
            if (slot == '0) begin
                blk_qp <= qp;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`default_nettype none

// ============================================================
// transform model
// ============================================================

// sign rows of the +-1 basis
function automatic int basis_sign(input int row, input int col);
    int sgn;
    case (row)
        0:       sgn = 1;
        1:       sgn = (col < 2) ? 1 : -1;
        2:       sgn = (col == 0 || col == 3) ? 1 : -1;
        default: sgn = (col % 2 == 0) ? 1 : -1;
    endcase
    return sgn;
endfunction

// coefficient k = 4u + v of a raster-order residual block
function automatic int transform_coef(input int res [16], input int k);
    int sum;
    sum = 0;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            sum += basis_sign(k / 4, y) * basis_sign(k % 4, x) * res[4 * y + x];
        end
    end
    return sum;
endfunction

// ============================================================
// quantizer model
// ============================================================

function automatic int lookup_mf(input int idx, input int qp);
    int r;
    int mf;
    r = qp % 6;
    if (idx == 0 || idx == 2 || idx == 8 || idx == 10) begin
        case (r)
            0: mf = 13107;
            1: mf = 11916;
            2: mf = 10082;
            3: mf = 9362;
            4: mf = 8192;
            default: mf = 7282;
        endcase
    end else if (idx == 5 || idx == 7 || idx == 13 || idx == 15) begin
        case (r)
            0: mf = 5243;
            1: mf = 4660;
            2: mf = 4194;
            3: mf = 3647;
            4: mf = 3355;
            default: mf = 2893;
        endcase
    end else begin
        case (r)
            0: mf = 8066;
            1: mf = 7490;
            2: mf = 6554;
            3: mf = 5825;
            4: mf = 5243;
            default: mf = 4559;
        endcase
    end
    return mf;
endfunction

function automatic int quantize_level(input int coef, input int idx, input int qp);
    int     qbits;
    longint f;
    longint mag;
    qbits = 15 + qp / 6;
    // offset is a third of 2^qbits rounded down
    f = (longint'(1) << qbits) / 3;
    mag = (longint'(coef < 0 ? -coef : coef) * lookup_mf(idx, qp) + f) >> qbits;
    return (coef < 0) ? -int'(mag) : int'(mag);
endfunction

`default_nettype wire

`endif

//--- tests/tb_intra_block_coder.sv
`include "tb_model.svh"

`default_nettype none

module tb_intra_block_coder
    import intra_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BLOCKS  = 71;
    localparam int MAX_GAP     = 5;
    localparam int CYCLE_LIMIT = NUM_BLOCKS * BLOCK_SAMPLES * (1 + MAX_GAP) + 400;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    pixel_t pixel;
    pixel_t pred;
    qp_t    qp;
    logic   out_valid;
    level_t out_level;

    int seed = 68986;
    int cycle = 0;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int blocks_sent = 0;
    int levels_checked = 0;

    // expected levels in output order with start cycle and id per block
    int exp_levels [$];
    int exp_start [$];
    int exp_block [$];

    int mon_pos = 0;
    int mon_prev = 0;
    int mon_block = 0;
    int mon_start;
    int mon_level;

    intra_block_coder uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pixel     (pixel),
        .pred      (pred),
        .qp        (qp),
        .out_valid (out_valid),
        .out_level (out_level)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d expected output levels never arrived",
                     cycle, exp_levels.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    // ============================================================
    // output monitor sampled mid-cycle
    // ============================================================

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_levels.size() == 0) begin
                $display("output level %h at cycle %0d with no block pending", out_level, cycle);
                errors++;
            end else begin
                if (mon_pos == 0) begin
                    mon_start = exp_start.pop_front();
                    mon_block = exp_block.pop_front();
                    if (cycle != mon_start) begin
                        $display("block %0d output started at cycle %0d instead of cycle %0d",
                                 mon_block, cycle, mon_start);
                        errors++;
                    end
                end else if (cycle != mon_prev + 1) begin
                    $display("block %0d output burst broke off before index %0d",
                             mon_block, mon_pos);
                    errors++;
                end
                mon_level = exp_levels.pop_front();
                // full-width compare so a wrapped level shows up
                if (out_level !== mon_level) begin
                    $display("Error: out_level = %h, expected %h, block %0d index %0d",
                             out_level, mon_level, mon_block, mon_pos);
                    errors++;
                end
                levels_checked++;
                mon_prev = cycle;
                mon_pos = (mon_pos + 1) % BLOCK_SAMPLES;
            end
        end else if (rst_n && out_level !== level_t'(0)) begin
            $display("Error: out_level = %h, expected %h while out_valid is low",
                     out_level, level_t'(0));
            errors++;
        end
    end

    // ============================================================
    // stimulus helpers
    // ============================================================

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // one sample per strobe with up to max_gap idle cycles before each
    task automatic send_block(input int pix [BLOCK_SAMPLES], input int prd [BLOCK_SAMPLES],
                              input int blk_qp, input int max_gap);
        int res [BLOCK_SAMPLES];
        int gap;
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            gap = rand_range(0, max_gap);
            repeat (gap) begin
                @(posedge clk);
                #2;
                in_valid = 1'b0;
                pixel = pixel_t'(rand_range(0, 255));
            end
            @(posedge clk);
            #2;
            in_valid = 1'b1;
            pixel = pixel_t'(pix[i]);
            pred = pixel_t'(prd[i]);
            // qp only matters on slot 0 so other slots carry junk
            qp = (i == 0) ? qp_t'(blk_qp) : qp_t'(rand_range(0, 31));
            res[i] = pix[i] - prd[i];
        end
        // accepted on the next edge and first level two edges after that
        exp_start.push_back(cycle + 3);
        exp_block.push_back(blocks_sent);
        for (int k = 0; k < BLOCK_SAMPLES; k++) begin
            exp_levels.push_back(quantize_level(transform_coef(res, k), k, blk_qp));
        end
        blocks_sent++;
    endtask

    task automatic send_random_block(input int max_gap);
        int pix [BLOCK_SAMPLES];
        int prd [BLOCK_SAMPLES];
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            pix[i] = rand_range(0, 255);
            prd[i] = rand_range(0, 255);
        end
        send_block(pix, prd, rand_range(0, QP_MAX), max_gap);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        while (exp_levels.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        int pix [BLOCK_SAMPLES];
        int prd [BLOCK_SAMPLES];
        int r;
        int err_start;
        rst_n = 1'b0;
        in_valid = 1'b0;
        pixel = '0;
        pred = '0;
        qp = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // quiet after reset and then pixel equal to prediction
        err_start = errors;
        repeat (20) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("Error: out_valid = %h, expected %h at cycle %0d with no input",
                         out_valid, 1'b0, cycle);
                errors++;
            end
        end
        for (int i = 0; i < BLOCK_SAMPLES; i++) begin
            pix[i] = rand_range(0, 255);
            prd[i] = pix[i];
        end
        send_block(pix, prd, rand_range(0, QP_MAX), 0);
        wait_drain();
        report_test("1 idle output and zero residual", err_start);

        // constant residual leaves only DC
        err_start = errors;
        for (int b = 0; b < 6; b++) begin
            r = rand_range(-255, 255);
            for (int i = 0; i < BLOCK_SAMPLES; i++) begin
                if (r >= 0) begin
                    prd[i] = rand_range(0, 255 - r);
                    pix[i] = prd[i] + r;
                end else begin
                    pix[i] = rand_range(0, 255 + r);
                    prd[i] = pix[i] - r;
                end
            end
            send_block(pix, prd, rand_range(0, QP_MAX), 2);
        end
        wait_drain();
        report_test("2 constant residual", err_start);

        err_start = errors;
        for (int b = 0; b < 40; b++) begin
            send_random_block(3);
        end
        wait_drain();
        report_test("3 random blocks", err_start);

        // back-to-back first and then random gaps
        err_start = errors;
        for (int b = 0; b < 8; b++) begin
            send_random_block(0);
        end
        for (int b = 0; b < 8; b++) begin
            send_random_block(MAX_GAP);
        end
        wait_drain();
        report_test("4 back-to-back and gapped blocks", err_start);

        // full-scale residual patterns at both QP ends
        err_start = errors;
        for (int n = 0; n < 2; n++) begin
            for (int p = 0; p < 4; p++) begin
                for (int i = 0; i < BLOCK_SAMPLES; i++) begin
                    case (p)
                        0:       r = 1;
                        1:       r = -1;
                        2:       r = ((i / 4 + i % 4) % 2 == 0) ? 1 : -1;
                        default: r = ((i / 4) % 2 == 0) ? 1 : -1;
                    endcase
                    pix[i] = (r > 0) ? 255 : 0;
                    prd[i] = 255 - pix[i];
                end
                send_block(pix, prd, (n == 0) ? 0 : QP_MAX, 1);
            end
        end
        wait_drain();
        report_test("5 extreme residuals", err_start);

        $display("tests ok: %0d, tests with errors: %0d, levels checked: %0d",
                 tests_passed, tests_failed, levels_checked);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
